/* rtg_display_checker.sv */
// RTG memory handshake checker
`timescale 1ns/1ps

module rtg_display_checker #(
	parameter int BURST_LEN = 4
) (
	input logic CLK_114,
	input logic rst_n,
	input logic mem_req,
	input logic mem_fill
);
	int   beats;	// Fills seen in current burst
	logic burst_end;

	assign burst_end = mem_fill && (beats == BURST_LEN - 1);

	always_ff @(posedge CLK_114 or negedge rst_n) begin
		if (!rst_n)
			beats <= 0;
		else if (mem_fill)
			beats <= burst_end ? 0 : beats + 1;
	end

	fill_needs_req: assert property (@(posedge CLK_114) disable iff (!rst_n)
		mem_fill |-> mem_req)
		else $error("mem_fill seen without mem_req");

	req_low_after_reset: assert property (@(posedge CLK_114)
		$rose(rst_n) |-> !mem_req)
		else $error("mem_req high right after reset");

	// Request may only drop once its last beat is in
	req_held_in_burst: assert property (@(posedge CLK_114) disable iff (!rst_n)
		mem_req && !burst_end |=> mem_req)
		else $error("mem_req dropped before burst completed");

endmodule

bind rtg_pixel_fifo rtg_display_checker #(
	.BURST_LEN (BURST_LEN)
) i_rtg_display_checker (
	.CLK_114  (CLK_114),
	.rst_n    (rst_n),
	.mem_req  (mem_req),
	.mem_fill (mem_fill)
);

/* rtg_display_tb.sv */
// RTG display path testbench
`timescale 1ns/1ps

module rtg_display_tb;
	import rtg_pkg::*;

	localparam int BURST_LEN = burst_len_default;
	localparam int NPIX      = 8;	// Pixels per active line
	localparam int HBLANK    = 24;	// Blank cycles per line
	localparam int NTESTS    = 6;

	typedef struct {
		string              name;
		logic               ena;
		logic               clut;
		logic [PIXW_W-1:0]  pw;
		logic               ext;
		logic [VBEND_W-1:0] vbend;
		logic [ADDR_W-1:0]  base;
		logic               osd_win;
		logic               osd_pix;
		int                 lines;	// Visible lines after vblank
	} test_t;

	logic CLK_114, rst_n, rtg_ena, rtg_clut_mode, rtg_ext;
	logic [PIXW_W-1:0]  pix_width;
	logic [VBEND_W-1:0] vbend;
	logic [ADDR_W-1:0]  base_addr, mem_addr;
	logic hblank_in, vblank_in, hsync_in, vsync_in, csync_in;
	logic osd_window, osd_pixel, mem_req, mem_fill, clut_we;
	logic [WORD_W-1:0]  mem_data;
	logic [7:0]         clut_idx;
	rgb_t               native_rgb, clut_rgb, vga_rgb;
	logic vga_hs, vga_vs, vga_cs;

	test_t             tests [NTESTS];
	test_t             cur;	// Entry being applied
	rgb_t              exp_pipe [2];	// Expected colour before OSD
	logic [2:0]        sync_pipe [2];	// hs, vs, cs
	logic [1:0]        valid_pipe = '0;
	logic              hs_prev = 1'b0;
	int                rises = 0;	// hsync rises since vblank_in
	int                act_cyc = 0;	// Cycle within visible line
	int                fetch_cnt = 0;	// Words popped this frame
	logic [ADDR_W-1:0] mem_exp = '0;	// Logical address of next burst
	int                restart_cnt = 0;
	int                restart_done = 0;
	int                bursts_served = 0;

	rtg_display_top #(.BURST_LEN(BURST_LEN)) i_rtg_display_top (.*);

	initial begin
		CLK_114 = 1'b0;
		forever #10 CLK_114 = ~CLK_114;	// 50 MHz stand-in
	end

	////////////////////////////////////////
	// Reference functions
	////////////////////////////////////////
	function automatic logic [ADDR_W-1:0] mangle(input logic [ADDR_W-1:0] a);
		logic [ADDR_W-1:0] m;
		m = a;
		m[23] = a[23] ^ (a[22] | a[21]);	// CPU address mangling
		return m;
	endfunction

	function automatic logic [WORD_W-1:0] word_at(input logic [ADDR_W-1:0] a);
		logic [WORD_W-1:0] x;
		x = a[16:1] * 16'h9e37;	// Scrambled word per address
		return x ^ {a[24:17], 8'h5a};
	endfunction

	function automatic rgb_t clut_color(input logic [7:0] i);
		rgb_t c;
		c.r = i ^ 8'h3c;
		c.g = ~i;
		c.b = {i[3:0], i[7:4]};
		return c;
	endfunction

	function automatic rgb_t expand555(input logic [WORD_W-1:0] w);
		rgb_t c;
		c.r = {w[14:10], w[14:12]};	// Top bits repeated below
		c.g = {w[9:5], w[9:7]};
		c.b = {w[4:0], w[4:2]};
		return c;
	endfunction

	function automatic rgb_t overlay(input rgb_t c, input logic win, input logic pix);
		rgb_t o;
		o = c;
		if (win) begin
			o.r[7:6] = pix ? 2'b11 : 2'b00;
			o.g[7:6] = pix ? 2'b11 : 2'b00;
			o.b[7:6] = pix ? 2'b11 : 2'b10;	// Blue tinted background
		end
		return o;
	endfunction

	////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////
	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1, "Simulation stopped on error");
	endtask

	task automatic check_rgb(input string what, input rgb_t exp, input rgb_t act);
		if (act !== exp)
			fail_run($sformatf("MISMATCH %s: expected %06h actual %06h", what, exp, act));
	endtask

	task automatic check_bit(input string what, input logic exp, input logic act);
		if (act !== exp)
			fail_run($sformatf("MISMATCH %s: expected %b actual %b", what, exp, act));
	endtask

	task automatic check_addr(input string what, input logic [ADDR_W-1:0] exp,
		input logic [ADDR_W-1:0] act);
		if (act !== exp)
			fail_run($sformatf("MISMATCH %s: expected %07h actual %07h", what, exp, act));
	endtask

	////////////////////////////////////////
	// Memory model
	////////////////////////////////////////
	always @(posedge CLK_114)
		if (rst_n && (vblank_in || !rtg_ena))
			restart_cnt++;	// FIFO rewinds to base

	initial begin : memory_model
		int lat;
		mem_fill = 1'b0;
		mem_data = '0;
		forever begin
			@(negedge CLK_114);
			mem_fill = 1'b0;
			if (restart_cnt != restart_done) begin
				mem_exp       = base_addr;
				restart_done  = restart_cnt;
				bursts_served = 0;
			end
			if (rst_n && mem_req) begin
				check_addr({cur.name, " mem_addr"}, mangle(mem_exp), mem_addr);
				lat = $urandom_range(3, 1);
				repeat (lat) @(negedge CLK_114);	// Random memory latency
				for (int i = 0; i < BURST_LEN; i++) begin
					if (i > 0)
						@(negedge CLK_114);
					mem_fill = 1'b1;
					mem_data = word_at(mem_exp + ADDR_W'(2 * i));
				end
				mem_exp = mem_exp + ADDR_W'(2 * BURST_LEN);
				bursts_served++;
			end
		end
	end

	////////////////////////////////////////
	// One clock of stimulus and checking
	////////////////////////////////////////
	task automatic tick(input logic hb, input logic hs, input logic vb);
		logic [31:0]       r;
		logic              vis;
		int                slot;
		logic [WORD_W-1:0] w;
		rgb_t              pix;
		@(negedge CLK_114);
		if (valid_pipe[1]) begin	// Output shows inputs of two cycles ago
			check_rgb({cur.name, " vga_rgb"},
				overlay(exp_pipe[1], osd_window, osd_pixel), vga_rgb);
			check_bit({cur.name, " vga_hs"}, sync_pipe[1][2], vga_hs);
			check_bit({cur.name, " vga_vs"}, sync_pipe[1][1], vga_vs);
			check_bit({cur.name, " vga_cs"}, sync_pipe[1][0], vga_cs);
		end
		r             = $urandom;
		rtg_ena       = cur.ena;
		rtg_clut_mode = cur.clut;
		rtg_ext       = cur.ext;
		pix_width     = cur.pw;
		vbend         = cur.vbend;
		base_addr     = cur.base;
		osd_window    = cur.osd_win;
		osd_pixel     = cur.osd_pix;
		hblank_in     = hb;
		hsync_in      = hs;
		vblank_in     = vb;
		native_rgb    = r[23:0];
		vsync_in      = r[24];
		csync_in      = r[25];
		if (vb)
			rises = 0;
		else if (hs && !hs_prev)
			rises++;
		hs_prev = hs;
		if (vb || !cur.ena)
			fetch_cnt = 0;	// Frame restart
		vis  = !hb && !vb && (rises >= int'(cur.vbend));
		slot = act_cyc % (int'(cur.pw) + 1);
		w    = word_at(cur.base + ADDR_W'(2 * fetch_cnt));
		if (!cur.ena)
			pix = native_rgb;
		else if (!vis)
			pix = '0;	// RTG blank
		else if (cur.clut)
			pix = clut_color(slot > int'(cur.pw >> 1) ? w[7:0] : w[15:8]);
		else
			pix = expand555(w);
		if (cur.ena && slot == int'(cur.pw) &&
			(vis || (cur.ext && !vb && act_cyc != 0)))
			fetch_cnt++;	// End of pixel time or extended pixel in blank
		act_cyc      = vis ? act_cyc + 1 : 0;
		exp_pipe[1]  = exp_pipe[0];
		exp_pipe[0]  = pix;
		sync_pipe[1] = sync_pipe[0];
		sync_pipe[0] = {hs, r[24], r[25]};
		valid_pipe   = {valid_pipe[0], 1'b1};
	endtask

	task automatic frame_start;
		int guard;
		repeat (3) tick(1'b1, 1'b0, 1'b1);	// vblank_in pulse
		guard = 0;
		while (cur.ena && (restart_cnt != restart_done || bursts_served < 2 || guard < 8)) begin
			tick(1'b1, 1'b0, 1'b0);	// Prefetch in blank
			guard++;
			if (guard > 60)
				fail_run("Timeout: FIFO prefetch did not complete after frame start");
		end
	endtask

	task automatic run_line;
		for (int i = 0; i < HBLANK; i++)
			tick(1'b1, (i >= 4 && i < 10), 1'b0);	// hsync inside hblank
		// Last pixel time ends in hblank when extended
		for (int i = 0; i < NPIX * (int'(cur.pw) + 1) - int'(cur.ext); i++)
			tick(1'b0, 1'b0, 1'b0);
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////
	initial begin
		void'($urandom(32'hf7738bb8));
		tests[0] = '{"native", 1'b0, 1'b0, 4'd3, 1'b0, 7'd0, 25'h0000000, 1'b0, 1'b0, 2};
		tests[1] = '{"hicolor", 1'b1, 1'b0, 4'd3, 1'b0, 7'd2, 25'h0200000, 1'b0, 1'b0, 3};
		tests[2] = '{"hicolor_ext", 1'b1, 1'b0, 4'd5, 1'b1, 7'd0, 25'h0600000, 1'b0, 1'b0, 3};
		tests[3] = '{"clut", 1'b1, 1'b1, 4'd7, 1'b0, 7'd1, 25'h1400000, 1'b0, 1'b0, 3};
		tests[4] = '{"osd_rtg", 1'b1, 1'b0, 4'd3, 1'b0, 7'd3, 25'h0a00000, 1'b1, 1'b1, 2};
		tests[5] = '{"osd_native", 1'b0, 1'b0, 4'd3, 1'b0, 7'd0, 25'h0000000, 1'b1, 1'b0, 2};
		cur = tests[0];
		{rtg_ena, rtg_clut_mode, rtg_ext, pix_width, vbend, base_addr} = '0;
		{hblank_in, vblank_in, hsync_in, vsync_in, csync_in} = '0;
		{osd_window, osd_pixel, clut_we, clut_idx} = '0;
		native_rgb = '0;
		clut_rgb   = '0;
		rst_n      = 1'b0;
		repeat (4) @(negedge CLK_114);
		check_bit("reset mem_req", 1'b0, mem_req);
		check_rgb("reset vga_rgb", '0, vga_rgb);
		check_bit("reset vga_hs", 1'b0, vga_hs);
		check_bit("reset vga_vs", 1'b0, vga_vs);
		check_bit("reset vga_cs", 1'b0, vga_cs);
		rst_n = 1'b1;
		for (int i = 0; i < 256; i++) begin	// Load whole CLUT
			tick(1'b1, 1'b0, 1'b0);
			clut_we  = 1'b1;
			clut_idx = 8'(i);
			clut_rgb = clut_color(8'(i));
		end
		tick(1'b1, 1'b0, 1'b0);
		clut_we = 1'b0;
		for (int t = 0; t < NTESTS; t++) begin
			cur = tests[t];
			frame_start();
			repeat (int'(cur.vbend) + cur.lines) run_line();
		end
		repeat (4) tick(1'b1, 1'b0, 1'b0);	// Drain output pipeline
		$display("Result: PASSED");
		$finish;
	end

endmodule

/* rtg_display_top.sv */
// RTG display path top level
`timescale 1ns/1ps

module rtg_display_top #(
	parameter int BURST_LEN = rtg_pkg::burst_len_default
) (
	input  logic                       CLK_114,
	input  logic                       rst_n,
	// RTG control
	input  logic                       rtg_ena,
	input  logic                       rtg_clut_mode,
	input  logic                       rtg_ext,
	input  logic [rtg_pkg::PIXW_W-1:0]  pix_width,
	input  logic [rtg_pkg::VBEND_W-1:0] vbend,
	input  logic [rtg_pkg::ADDR_W-1:0]  base_addr,
	// Native video
	input  logic                       hblank_in,
	input  logic                       vblank_in,
	input  logic                       hsync_in,
	input  logic                       vsync_in,
	input  logic                       csync_in,
	input  rtg_pkg::rgb_t              native_rgb,
	// OSD
	input  logic                       osd_window,
	input  logic                       osd_pixel,
	// Memory burst port
	output logic                       mem_req,
	output logic [rtg_pkg::ADDR_W-1:0]  mem_addr,
	input  logic                       mem_fill,
	input  logic [rtg_pkg::WORD_W-1:0]  mem_data,
	// CLUT write
	input  logic                       clut_we,
	input  logic [7:0]                 clut_idx,
	input  rtg_pkg::rgb_t              clut_rgb,
	// Video out
	output rtg_pkg::rgb_t              vga_rgb,
	output logic                       vga_hs,
	output logic                       vga_vs,
	output logic                       vga_cs
);
	import rtg_pkg::*;

	logic        vblank;	// Extended vblank
	logic        blank;
	logic        fetch;
	logic        byte_sel;
	pixel_word_t word;	// FIFO head

	rtg_vblank_gen i_rtg_vblank_gen (
		.CLK_114   (CLK_114),
		.rst_n     (rst_n),
		.vblank_in (vblank_in),
		.hsync_in  (hsync_in),
		.vbend     (vbend),
		.vblank    (vblank)
	);

	rtg_fetch_timer i_rtg_fetch_timer (
		.CLK_114   (CLK_114),
		.rst_n     (rst_n),
		.rtg_ena   (rtg_ena),
		.rtg_ext   (rtg_ext),
		.pix_width (pix_width),
		.hblank_in (hblank_in),
		.vblank    (vblank),
		.fetch     (fetch),
		.byte_sel  (byte_sel),
		.blank     (blank)
	);

	rtg_pixel_fifo #(
		.BURST_LEN (BURST_LEN)
	) i_rtg_pixel_fifo (
		.CLK_114   (CLK_114),
		.rst_n     (rst_n),
		.rtg_ena   (rtg_ena),
		.vblank_in (vblank_in),
		.base_addr (base_addr),
		.fetch     (fetch),
		.mem_req   (mem_req),
		.mem_addr  (mem_addr),
		.mem_fill  (mem_fill),
		.mem_data  (mem_data),
		.word      (word)
	);

	rtg_pixel_decode i_rtg_pixel_decode (
		.CLK_114       (CLK_114),
		.rst_n         (rst_n),
		.rtg_ena       (rtg_ena),
		.rtg_clut_mode (rtg_clut_mode),
		.blank         (blank),
		.byte_sel      (byte_sel),
		.word          (word),
		.native_rgb    (native_rgb),
		.hsync_in      (hsync_in),
		.vsync_in      (vsync_in),
		.csync_in      (csync_in),
		.osd_window    (osd_window),
		.osd_pixel     (osd_pixel),
		.clut_we       (clut_we),
		.clut_idx      (clut_idx),
		.clut_rgb      (clut_rgb),
		.vga_rgb       (vga_rgb),
		.vga_hs        (vga_hs),
		.vga_vs        (vga_vs),
		.vga_cs        (vga_cs)
	);

endmodule

/* rtg_fetch_timer.sv */
// RTG fetch timer
// Pixel-time divider and CLUT byte select
`timescale 1ns/1ps

module rtg_fetch_timer (
	input  logic                      CLK_114,
	input  logic                      rst_n,
	input  logic                      rtg_ena,
	input  logic                      rtg_ext,	// One extra pixel after active area
	input  logic [rtg_pkg::PIXW_W-1:0] pix_width,	// Clocks per fetch minus one
	input  logic                      hblank_in,
	input  logic                      vblank,	// Extended RTG vblank
	output logic                      fetch,	// FIFO read strobe
	output logic                      byte_sel,	// Low CLUT byte when set
	output logic                      blank
);
	import rtg_pkg::*;

	logic [PIXW_W-1:0] pix_ctr;	// Compared against pix_width
	logic [PIXW_W-1:0] half_width;
	logic              blank_d;	// Blank one cycle ago

	assign blank      = vblank | hblank_in;
	assign half_width = pix_width >> 1;	// Byte swap point within pixel

	// Strobe at end of pixel time, one extended pixel after active area
	assign fetch = rtg_ena && (pix_ctr == pix_width) &&
		(!blank || (!blank_d && rtg_ext));

	always_ff @(posedge CLK_114 or negedge rst_n) begin
		if (!rst_n) begin
			pix_ctr  <= '0;
			blank_d  <= 1'b0;
			byte_sel <= 1'b0;
		end else begin
			blank_d <= blank;
			if (blank || fetch) begin	// Restart pixel time
				pix_ctr  <= '0;
				byte_sel <= 1'b0;	// High byte first
			end else begin
				pix_ctr <= pix_ctr + 1'b1;
				if (pix_ctr == half_width)
					byte_sel <= 1'b1;	// Second half shows low byte
			end
		end
	end

endmodule

/* rtg_pixel_decode.sv */
// RTG pixel decode
// High-colour and CLUT decode, native select and OSD overlay
`timescale 1ns/1ps

module rtg_pixel_decode (
	input  logic                 CLK_114,
	input  logic                 rst_n,
	input  logic                 rtg_ena,
	input  logic                 rtg_clut_mode,	// 8-bit indexed when set
	input  logic                 blank,
	input  logic                 byte_sel,
	input  rtg_pkg::pixel_word_t word,
	input  rtg_pkg::rgb_t        native_rgb,	// Chipset video
	input  logic                 hsync_in,
	input  logic                 vsync_in,
	input  logic                 csync_in,
	input  logic                 osd_window,
	input  logic                 osd_pixel,
	input  logic                 clut_we,
	input  logic [7:0]           clut_idx,
	input  rtg_pkg::rgb_t        clut_rgb,
	output rtg_pkg::rgb_t        vga_rgb,
	output logic                 vga_hs,
	output logic                 vga_vs,
	output logic                 vga_cs
);
	import rtg_pkg::*;

	rgb_t       clut_ram [256];
	rgb_t       hc_rgb;	// RGB555 expanded to 8 bits
	rgb_t       hc_q;	// Stage 1 colours
	rgb_t       clut_q;
	rgb_t       native_q;
	rgb_t       pix_q;	// Stage 2 selected colour
	logic [7:0] rd_idx;
	logic       hs_q, vs_q, cs_q;	// Stage 1 syncs
	logic       blank_q, ena_q, mode_q;	// Stage 1 select
	logic [1:0] osd_r, osd_g, osd_b;

	////////////////////////////////////////
	// Stage 0 decode
	////////////////////////////////////////
	assign rd_idx   = byte_sel ? word.clut.lo : word.clut.hi;	// High byte first
	assign hc_rgb.r = {word.rgb555.r, word.rgb555.r[4:2]};
	assign hc_rgb.g = {word.rgb555.g, word.rgb555.g[4:2]};
	assign hc_rgb.b = {word.rgb555.b, word.rgb555.b[4:2]};

	// CLUT RAM, one cycle read
	always_ff @(posedge CLK_114) begin
		if (clut_we)
			clut_ram[clut_idx] <= clut_rgb;
		clut_q   <= clut_ram[rd_idx];
		hc_q     <= hc_rgb;	// Matched to lookup
		native_q <= native_rgb;
	end

	////////////////////////////////////////
	// Stage 1 and 2 control
	////////////////////////////////////////
	always_ff @(posedge CLK_114 or negedge rst_n) begin
		if (!rst_n) begin
			hs_q    <= 1'b0;
			vs_q    <= 1'b0;
			cs_q    <= 1'b0;
			blank_q <= 1'b0;
			ena_q   <= 1'b0;
			mode_q  <= 1'b0;
			pix_q   <= '0;
			vga_hs  <= 1'b0;
			vga_vs  <= 1'b0;
			vga_cs  <= 1'b0;
		end else begin
			hs_q    <= hsync_in;
			vs_q    <= vsync_in;
			cs_q    <= csync_in;
			blank_q <= blank;
			ena_q   <= rtg_ena;
			mode_q  <= rtg_clut_mode;
			vga_hs  <= hs_q;
			vga_vs  <= vs_q;
			vga_cs  <= cs_q;
			if (!ena_q)
				pix_q <= native_q;	// Chipset video
			else if (blank_q)
				pix_q <= '0;	// Black in RTG blank
			else
				pix_q <= mode_q ? clut_q : hc_q;
		end
	end

	////////////////////////////////////////
	// OSD overlay on top two bits
	////////////////////////////////////////
	assign osd_r = osd_pixel ? OSD_FG_R : OSD_BG_R;
	assign osd_g = osd_pixel ? OSD_FG_G : OSD_BG_G;
	assign osd_b = osd_pixel ? OSD_FG_B : OSD_BG_B;

	assign vga_rgb.r = osd_window ? {osd_r, pix_q.r[COLOR_W-3:0]} : pix_q.r;
	assign vga_rgb.g = osd_window ? {osd_g, pix_q.g[COLOR_W-3:0]} : pix_q.g;
	assign vga_rgb.b = osd_window ? {osd_b, pix_q.b[COLOR_W-3:0]} : pix_q.b;

endmodule

/* rtg_pixel_fifo.sv */
// RTG pixel FIFO
// Prefetching word buffer with burst memory requests
`timescale 1ns/1ps

module rtg_pixel_fifo #(
	parameter int BURST_LEN = rtg_pkg::burst_len_default
) (
	input  logic                      CLK_114,
	input  logic                      rst_n,
	input  logic                      rtg_ena,
	input  logic                      vblank_in,	// Chipset vblank starts a new frame
	input  logic [rtg_pkg::ADDR_W-1:0] base_addr,	// Frame start, byte address
	input  logic                      fetch,	// Pop head word
	output logic                      mem_req,
	output logic [rtg_pkg::ADDR_W-1:0] mem_addr,	// Mangled byte address
	input  logic                      mem_fill,	// One burst word this cycle
	input  logic [rtg_pkg::WORD_W-1:0] mem_data,
	output rtg_pkg::pixel_word_t      word	// Show-ahead head word
);
	import rtg_pkg::*;

	localparam int PTR_W       = $clog2(FIFO_DEPTH);
	localparam int LVL_W       = PTR_W + 1;
	localparam int CNT_W       = $clog2(BURST_LEN + 1);
	localparam int BURST_BYTES = 2 * BURST_LEN;	// Two bytes per word
	localparam logic [CNT_W-1:0] LAST_BEAT = CNT_W'(BURST_LEN - 1);
	localparam logic [LVL_W-1:0] REQ_LEVEL = LVL_W'(FIFO_DEPTH - BURST_LEN);

	logic [WORD_W-1:0] fifo_mem [FIFO_DEPTH];
	logic [WORD_W-1:0] last_word;	// Repeated on underrun
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [LVL_W-1:0]  level;	// Words held
	logic [LVL_W-1:0]  level_nxt;
	logic [CNT_W-1:0]  fill_cnt;	// Beats received in current burst
	logic [ADDR_W-1:0] addr_q;	// Logical address of next burst
	logic              discard;	// Burst belongs to old frame
	logic              restart;
	logic              wr_en;
	logic              rd_en;
	logic              last_fill;
	logic              burst_due;

	////////////////////////////////////////
	// Level and handshake decode
	////////////////////////////////////////
	assign restart   = vblank_in | ~rtg_ena;	// New frame
	assign wr_en     = mem_fill & ~discard & ~restart;
	assign rd_en     = fetch & (level != '0);	// Empty read repeats last word
	assign last_fill = mem_req & mem_fill & (fill_cnt == LAST_BEAT);
	assign level_nxt = level + LVL_W'(wr_en) - LVL_W'(rd_en);
	assign burst_due = ~restart & (level_nxt <= REQ_LEVEL);	// Room for a whole burst

	// CPU address mangling on bit 23
	assign mem_addr = {addr_q[24], addr_q[23] ^ (addr_q[22] | addr_q[21]), addr_q[22:0]};

	assign word = (level != '0) ? pixel_word_t'(fifo_mem[rd_ptr]) : pixel_word_t'(last_word);

	////////////////////////////////////////
	// Storage
	////////////////////////////////////////
	always_ff @(posedge CLK_114) begin
		if (wr_en)
			fifo_mem[wr_ptr] <= mem_data;
		if (rd_en)
			last_word <= fifo_mem[rd_ptr];	// Keep popped word
	end

	////////////////////////////////////////
	// Pointers, level and burst control
	////////////////////////////////////////
	always_ff @(posedge CLK_114 or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			level    <= '0;
			fill_cnt <= '0;
			addr_q   <= '0;
			mem_req  <= 1'b0;
			discard  <= 1'b0;
		end else begin
			if (restart) begin	// Empty and rewind to frame start
				wr_ptr <= '0;
				rd_ptr <= '0;
				level  <= '0;
				addr_q <= base_addr;
			end else begin
				level <= level_nxt;
				if (wr_en)
					wr_ptr <= wr_ptr + 1'b1;
				if (rd_en)
					rd_ptr <= rd_ptr + 1'b1;
				if (last_fill && !discard)
					addr_q <= addr_q + ADDR_W'(BURST_BYTES);	// Next burst
			end

			if (mem_req) begin	// Burst in flight runs to completion
				if (mem_fill)
					fill_cnt <= last_fill ? '0 : fill_cnt + 1'b1;
				if (last_fill) begin
					mem_req <= burst_due;	// Back to back if room
					discard <= 1'b0;
				end else if (restart) begin
					discard <= 1'b1;	// Drop rest of stale burst
				end
			end else begin
				mem_req <= burst_due;
			end
		end
	end

endmodule

/* rtg_pkg.sv */
// RTG display path
// Shared widths, types and constants
package rtg_pkg;

	////////////////////////////////////////
	// Widths and sizes
	////////////////////////////////////////
	localparam int ADDR_W            = 25;	// Memory byte address
	localparam int WORD_W            = 16;	// Fetched pixel word
	localparam int COLOR_W           = 8;	// One colour channel
	localparam int PIXW_W            = 4;	// Clocks per fetch minus one
	localparam int VBEND_W           = 7;	// Extra vblank lines
	localparam int FIFO_DEPTH        = 16;	// Words in pixel FIFO
	localparam int burst_len_default = 4;	// Words per memory burst

	////////////////////////////////////////
	// Pixel word views
	////////////////////////////////////////
	typedef struct packed {
		logic       pad;	// Unused top bit
		logic [4:0] r;
		logic [4:0] g;
		logic [4:0] b;
	} rgb555_t;

	typedef struct packed {
		logic [7:0] hi;	// First pixel shown
		logic [7:0] lo;	// Second pixel shown
	} clut_pair_t;

	// One fetched word, high-colour or two CLUT indices
	typedef union packed {
		rgb555_t    rgb555;
		clut_pair_t clut;
	} pixel_word_t;

	typedef struct packed {
		logic [COLOR_W-1:0] r;
		logic [COLOR_W-1:0] g;
		logic [COLOR_W-1:0] b;
	} rgb_t;

	// OSD top bits, foreground pixel and window background
	localparam logic [1:0] OSD_FG_R = 2'b11;
	localparam logic [1:0] OSD_FG_G = 2'b11;
	localparam logic [1:0] OSD_FG_B = 2'b11;
	localparam logic [1:0] OSD_BG_R = 2'b00;
	localparam logic [1:0] OSD_BG_G = 2'b00;
	localparam logic [1:0] OSD_BG_B = 2'b10;	// Bluish tint behind text

endpackage

/* rtg_vblank_gen.sv */
// RTG vertical blank
`timescale 1ns/1ps

module rtg_vblank_gen (
	input  logic                       CLK_114,
	input  logic                       rst_n,
	input  logic                       vblank_in,	// Chipset vblank
	input  logic                       hsync_in,
	input  logic [rtg_pkg::VBEND_W-1:0] vbend,	// Extra lines after chipset vblank
	output logic                       vblank
);
	import rtg_pkg::*;

	logic [VBEND_W-1:0] line_cnt;	// Lines since chipset vblank
	logic               hs_d;	// Delayed hsync for edge detect
	logic               hs_rise;

	assign hs_rise = hsync_in & ~hs_d;

	always_ff @(posedge CLK_114 or negedge rst_n) begin
		if (!rst_n) begin
			vblank   <= 1'b0;
			line_cnt <= '0;
			hs_d     <= 1'b0;
		end else begin
			hs_d <= hsync_in;
			if (vblank_in) begin	// Hold and rearm count
				vblank   <= 1'b1;
				line_cnt <= '0;
			end else if (line_cnt == vbend) begin
				vblank <= 1'b0;	// Extension done
			end else if (vblank && hs_rise) begin
				line_cnt <= line_cnt + 1'b1;	// One more line
			end
		end
	end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the RTG display testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert --timing -j 0 \
	--top-module rtg_display_tb \
	-f verilog.f \
	-o rtg_display_sim
./obj_dir/rtg_display_sim

/* verilog.f */
rtg_pkg.sv
rtg_fetch_timer.sv
rtg_vblank_gen.sv
rtg_pixel_fifo.sv
rtg_pixel_decode.sv
rtg_display_top.sv
rtg_display_checker.sv
rtg_display_tb.sv
